// File: files.f
+incdir+testbench
hw/crc_defs_pkg.sv
hw/fcs_bus_pkg.sv
hw/crc_word_align.sv
hw/crc32_d64_next.sv
hw/crc_accum.sv
hw/crc_frame_ctrl.sv
hw/fcs_crc64_top.sv
testbench/tb_fcs_crc64.sv

// File: testbench/tb_fcs_ref.svh
// xorshift generator, bytewise reference CRC-32 and the value check task
`ifndef tb_fcs_ref_svh
`define tb_fcs_ref_svh

localparam logic [31:0] crc_poly_refl = 32'hedb8_8320;	// 04c11db7 bit-reversed

// 32-bit xorshift, state kept in rng_state
function automatic logic [31:0] next_rand();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// Ethernet CRC over the covered bytes of frame_buf[0..n-1]
// full words first, then bytes 0..k-1 of the last word (all when k is 0)
function automatic logic [31:0] ref_crc32(input int n, input int k);
	logic [31:0] c;
	logic [7:0] b;
	int nbytes;
	c = 32'hffff_ffff;
	for (int w = 0; w < n; w++)
	begin
		nbytes = (w == n - 1 && k != 0) ? k : 8;
		for (int j = 0; j < nbytes; j++)
		begin
			b = frame_buf[w][8*j +: 8];
			c = c ^ {24'h0, b};
			for (int i = 0; i < 8; i++)
				c = c[0] ? ((c >> 1) ^ crc_poly_refl) : (c >> 1);	// lsb first
		end
	end
	return ~c;
endfunction

task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
	if (got !== exp)
	begin
		$display("ERR @%0t ns: %s, expected %0h, got %0h", $time, what, exp, got);
		$display("TEST FAILED");
		$fatal(1, "stopped at first mismatch");
	end
endtask

`endif

// File: testbench/tb_fcs_crc64.sv
// testbench for the FCS CRC-32 top: clock, reset, watchdog and directed tests
module tb_fcs_crc64
	import crc_defs_pkg::*, fcs_bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_half = 20;
	localparam int max_words = 12;
	localparam int frames_per_off = 6;
	localparam int gap_frames = 8;	// each sent twice
	localparam int result_wait_max = 8;	// cycles, last word to vld plus slack
	localparam int frame_cycles = 3 * max_words + result_wait_max + 4;
	localparam int total_frames = 1 + bytes_per_word * frames_per_off + 2 * gap_frames + 2;
	localparam int budget_cycles = 4 + 16 + 12 + total_frames * frame_cycles;
	localparam int watchdog_ns = budget_cycles * 2 * clk_half + 1000;

	logic clk;
	logic rst_;
	logic clr;
	fcs_beat_t beat;
	fcs_result_t result;

	logic [31:0] rng_state;
	logic [63:0] frame_buf [max_words];

	`include "tb_fcs_ref.svh"

	fcs_crc64_top u_dut
	(
		.clk(clk),
		.rst_(rst_),
		.beat(beat),
		.clr(clr),
		.result(result)
	);

	always #clk_half clk = ~clk;

	// step to 2 ns past the next rising edge
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic drive_beat(input logic valid, input logic last, input byte_off_t off,
		input logic [63:0] data);
		beat.valid = valid;
		beat.last = last;
		beat.offset = off;
		beat.data = data;
	endtask

	task automatic fill_random(input int n);
		for (int w = 0; w < n; w++)
			frame_buf[w] = {next_rand(), next_rand()};
	endtask

	// words from frame_buf, optional idle cycles between them
	task automatic send_frame(input int n, input byte_off_t k, input bit gaps);
		int g;
		for (int w = 0; w < n; w++)
		begin
			if (gaps && w > 0)
			begin
				g = next_rand() % 3;
				repeat (g)
				begin
					drive_beat(1'b0, 1'b0, k, {next_rand(), next_rand()});	// junk data
					tick();
				end
			end
			drive_beat(1'b1, w == n - 1, k, frame_buf[w]);
			tick();
		end
		drive_beat(1'b0, 1'b0, k, '0);
	endtask

	task automatic wait_result();
		int cnt;
		cnt = 0;
		while (result.vld !== 1'b1)
		begin
			if (cnt == result_wait_max)
			begin
				$display("timeout: result valid did not rise within %0d cycles", result_wait_max);
				$display("TEST FAILED");
				$fatal(1, "no result from DUT");
			end
			else
			begin
				tick();
				cnt++;
			end
		end
	endtask

	task automatic release_result();
		clr = 1'b1;
		tick();
		clr = 1'b0;
		check_equal(result.vld, 1'b0, "result valid in the cycle after clear");
	endtask

	task automatic run_frame(input int n, input byte_off_t k, input bit gaps,
		output logic [31:0] crc);
		send_frame(n, k, gaps);
		wait_result();
		crc = result.crc;
		release_result();
	endtask

	task automatic check_reset_quiet();
		repeat (10)
		begin
			check_equal(result.vld, 1'b0, "result valid after reset with no words");
			tick();
		end
	endtask

	// check string split over two words at offset 1
	task automatic run_known_vector();
		frame_buf[0] = 64'h3837_3635_3433_3231;
		frame_buf[1] = 64'ha5a5_a5a5_a5a5_a539;	// only byte 0 counts
		check_equal(ref_crc32(2, 1), 32'hcbf4_3926, "reference model on check string");
		send_frame(2, 3'd1, 1'b0);
		check_equal(result.vld, 1'b0, "result valid at the last word edge");
		tick();
		check_equal(result.vld, 1'b0, "result valid one cycle after last word");
		tick();
		check_equal(result.vld, 1'b1, "result valid two cycles after last word");
		check_equal(result.crc, 32'hcbf4_3926, "crc of check string");
		release_result();
	endtask

	task automatic sweep_offsets();
		int n;
		logic [31:0] got;
		for (int k = 0; k < bytes_per_word; k++)
		begin
			for (int f = 0; f < frames_per_off; f++)
			begin
				if (f == 0)
					n = 1;
				else if (f == 1)
					n = max_words;
				else
					n = 1 + next_rand() % max_words;
				fill_random(n);
				run_frame(n, byte_off_t'(k), 1'b0, got);
				check_equal(got, ref_crc32(n, k),
					$sformatf("crc at offset %0d, %0d words", k, n));
			end
		end
	endtask

	task automatic compare_with_gaps();
		int n;
		logic [31:0] plain;
		logic [31:0] gapped;
		for (int k = 0; k < gap_frames; k++)
		begin
			n = 2 + next_rand() % (max_words - 1);
			fill_random(n);
			run_frame(n, byte_off_t'(k), 1'b0, plain);
			run_frame(n, byte_off_t'(k), 1'b1, gapped);
			check_equal(plain, ref_crc32(n, k), $sformatf("crc without gaps, offset %0d", k));
			check_equal(gapped, plain, $sformatf("crc with gaps, offset %0d", k));
		end
	endtask

	task automatic hold_and_clear();
		logic [31:0] held;
		logic [31:0] got;
		fill_random(5);
		send_frame(5, 3'd3, 1'b0);
		wait_result();
		held = result.crc;
		check_equal(held, ref_crc32(5, 3), "crc before extra words");
		for (int i = 0; i < 4; i++)
		begin
			drive_beat(1'b1, i[0], 3'd3, {next_rand(), next_rand()});	// must be dropped
			tick();
			check_equal(result.vld, 1'b1, "result valid while held");
			check_equal(result.crc, held, "held crc after extra word");
		end
		drive_beat(1'b0, 1'b0, 3'd3, '0);
		tick();
		release_result();
		tick();
		check_equal(result.vld, 1'b0, "result valid after clear with no frame");
		fill_random(7);
		run_frame(7, 3'd6, 1'b0, got);
		check_equal(got, ref_crc32(7, 6), "crc of frame after clear");
	endtask

	initial
	begin
		#(watchdog_ns);
		$display("watchdog: run did not finish within %0d ns", watchdog_ns);
		$display("TEST FAILED");
		$fatal(1, "watchdog timeout");
	end

	initial
	begin
		clk = 1'b0;
		rst_ = 1'b0;
		clr = 1'b0;
		rng_state = 32'hc259_42a0;
		drive_beat(1'b0, 1'b0, 3'd0, '0);
		repeat (4) @(posedge clk);
		#2;
		rst_ = 1'b1;

		check_reset_quiet();
		run_known_vector();
		sweep_offsets();
		compare_with_gaps();
		hold_and_clear();

		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: hw/fcs_crc64_top.sv
// FCS top: frame controller, word realignment and CRC accumulator
module fcs_crc64_top
	import crc_defs_pkg::*, fcs_bus_pkg::*;
(
	input logic clk,
	input logic rst_,
	input fcs_beat_t beat,
	input logic clr,
	output fcs_result_t result
);

	logic accept;
	accum_op_t accum_op;
	aligned_word_t aligned;
	logic first;
	byte_off_t frame_off;
	logic res_vld;
	crc_t res_crc;

	crc_frame_ctrl u_ctrl
	(
		.clk(clk),
		.rst_(rst_),
		.beat_valid(beat.valid),
		.beat_last(beat.last),
		.clr(clr),
		.accept(accept),
		.accum_op(accum_op),
		.vld(res_vld)
	);

	crc_word_align u_align
	(
		.clk(clk),
		.rst_(rst_),
		.beat(beat),
		.accept(accept),
		.word(aligned),
		.first(first),
		.offset(frame_off)
	);

	crc_accum u_accum
	(
		.clk(clk),
		.rst_(rst_),
		.word(aligned),
		.first(first),
		.offset(frame_off),
		.op(accum_op),
		.crc(res_crc)
	);

	assign result = '{vld: res_vld, crc: res_crc};

endmodule

// File: hw/crc_frame_ctrl.sv
// frame FSM: word accept, accumulate op and held result flag
module crc_frame_ctrl
	import crc_defs_pkg::*;
(
	input logic clk,
	input logic rst_,
	input logic beat_valid,
	input logic beat_last,
	input logic clr,
	output logic accept,
	output accum_op_t accum_op,
	output logic vld
);

	typedef enum logic [1:0]
	{
		idle,
		calc,
		done
	} state_t;

	state_t state;
	logic [1:0] last_pipe;	// last word through align, then through accum
	logic release_res;

	// no back-pressure, words are dropped while a result is held
	assign accept = beat_valid && (state != done);

	assign release_res = (state == done) && vld && clr;

	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			state <= idle;
			accum_op <= acc_hold;
			last_pipe <= 2'b00;
			vld <= 1'b0;
		end
		else
		begin
			// op follows the word one stage later, as it leaves align
			if (!accept)
				accum_op <= acc_hold;
			else if (state == idle)
				accum_op <= acc_load;
			else
				accum_op <= acc_update;

			last_pipe <= {last_pipe[0], accept && beat_last};

			case (state)
				idle:
				begin
					if (accept)
						state <= beat_last ? done : calc;
				end
				calc:
				begin
					if (accept && beat_last)
						state <= done;
				end
				done:
				begin
					if (release_res)
						state <= idle;
				end
				default: state <= idle;
			endcase

			if (last_pipe[1])
				vld <= 1'b1;	// crc register settled a cycle ago
			else if (release_res)
				vld <= 1'b0;
		end
	end

endmodule

// File: hw/crc_accum.sv
// CRC register: seed load, 64-bit update step, reflected and complemented output
module crc_accum
	import crc_defs_pkg::*, fcs_bus_pkg::*;
(
	input logic clk,
	input logic rst_,
	input aligned_word_t word,
	input logic first,
	input byte_off_t offset,
	input accum_op_t op,
	output crc_t crc
);

	crc_t crc_reg;
	crc_t base;
	crc_t stepped;
	data_word_t data_rev;

	// byte 0 bit 0 must reach the LFSR first
	always_comb
	begin
		for (int i = 0; i < data_w; i++)
			data_rev[i] = word[data_w-1-i];
	end

	assign base = first ? crc_seed_tab[offset] : crc_reg;	// seed on frame start

	crc32_d64_next u_next
	(
		.crc(base),
		.data(data_rev),
		.next_crc(stepped)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_)
			crc_reg <= '0;
		else
		begin
			case (op)
				acc_load,
				acc_update: crc_reg <= stepped;
				default: crc_reg <= crc_reg;
			endcase
		end
	end

	// bits reversed in each byte and bytes swapped, then complemented
	always_comb
	begin
		for (int b = 0; b < crc_w / 8; b++)
		begin
			for (int i = 0; i < 8; i++)
				crc[8*(crc_w/8 - 1 - b) + i] = ~crc_reg[8*b + 7 - i];
		end
	end

endmodule

// File: hw/crc32_d64_next.sv
// combinational CRC-32 update over one 64-bit word, msb first
module crc32_d64_next
	import crc_defs_pkg::*, fcs_bus_pkg::*;
(
	input crc_t crc,
	input data_word_t data,
	output crc_t next_crc
);

	// one division step per data bit, data[63] enters first
	// same XOR matrix as a hand-expanded 64-bit parallel CRC
	always_comb
	begin
		crc_t c;
		logic fb;
		c = crc;
		for (int i = data_w - 1; i >= 0; i--)
		begin
			fb = c[crc_w-1] ^ data[i];
			c = {c[crc_w-2:0], 1'b0};
			if (fb)
				c = c ^ crc_poly;
		end
		next_crc = c;
	end

endmodule

// File: hw/crc_word_align.sv
// previous word register and byte offset realignment ahead of the CRC
module crc_word_align
	import crc_defs_pkg::*, fcs_bus_pkg::*;
(
	input logic clk,
	input logic rst_,
	input fcs_beat_t beat,
	input logic accept,
	output aligned_word_t word,
	output logic first,
	output byte_off_t offset
);

	data_word_t prev;
	aligned_word_t aligned;
	logic start;	// next accepted word opens a frame

	// upper k lanes take the new word's low k bytes,
	// lower lanes take bytes k..7 of the word before it
	always_comb
	begin
		int unsigned k;
		k = beat.offset;
		for (int j = 0; j < bytes_per_word; j++)
		begin
			if (k == 0)
				aligned[8*j +: 8] = beat.data[8*j +: 8];
			else if (j >= bytes_per_word - k)
				aligned[8*j +: 8] = beat.data[8*(j - (bytes_per_word - k)) +: 8];
			else if (start)
				aligned[8*j +: 8] = 8'h00;	// pad, cancelled by the seed
			else
				aligned[8*j +: 8] = prev[8*(j + k) +: 8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			start <= 1'b1;
			first <= 1'b0;
		end
		else if (accept)
		begin
			start <= beat.last;
			first <= start;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			prev <= beat.data;
			word <= aligned;
			offset <= beat.offset;
		end
	end

endmodule

// File: hw/fcs_bus_pkg.sv
// frame check port types: data word, input beat, held result, realigned word
package fcs_bus_pkg;

	import crc_defs_pkg::*;

	// byte j in bits 8j+7 down to 8j, byte 0 first on the wire
	typedef logic [data_w-1:0] data_word_t;

	typedef struct packed
	{
		logic valid;
		logic last;
		byte_off_t offset;	// constant over a frame
		data_word_t data;
	} fcs_beat_t;

	typedef struct packed
	{
		logic vld;
		crc_t crc;	// conventional numeric form
	} fcs_result_t;

	// previous word and new word merged, still in wire byte order
	typedef logic [data_w-1:0] aligned_word_t;

endpackage

// File: hw/crc_defs_pkg.sv
// CRC-32 constants, per-offset seed table, CRC word and accumulate op types
package crc_defs_pkg;

	// word geometry
	localparam int data_w = 64;
	localparam int bytes_per_word = 8;

	localparam int crc_w = 32;

	// generator in normal form, x^32 term implied
	localparam logic [crc_w-1:0] crc_poly = 32'h04c1_1db7;

	localparam logic [crc_w-1:0] crc_init_ones = 32'hffff_ffff;

	typedef logic [crc_w-1:0] crc_t;

	// number of frame bytes in the last word, 0 means all eight
	typedef logic [$clog2(bytes_per_word)-1:0] byte_off_t;

	// what the accumulator does on the next edge
	typedef enum logic [1:0]
	{
		acc_hold,
		acc_load,
		acc_update
	} accum_op_t;

	// register seeds indexed by offset
	// the zero lanes below the first bytes of a frame run the seed
	// back to all ones before the first real byte is shifted in
	localparam crc_t crc_seed_tab [bytes_per_word] = '{
		crc_init_ones,
		32'h955a_6162,
		32'h68b9_32f5,
		32'h339f_de2f,
		32'h46af_6449,
		32'h8164_74c5,
		32'h09b9_3859,
		32'h9bf1_a90f
	};

endpackage
